//--- project.f
+incdir+verilog
verilog/pcie_pkg.sv
verilog/pcie_ifs.sv
verilog/req_dispatch.sv
verilog/bar_region.sv
verilog/cpl_arbiter.sv
verilog/fpga_core.sv
tests/tb_clock.sv
tests/tb_fpga_core.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
# The exit status is non-zero unless the log holds the pass line.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    -f project.f \
    --top-module tb_fpga_core \
    -o tb_fpga_core

./obj_dir/tb_fpga_core > sim.log 2>&1 || true
cat sim.log

if grep -q "^RESULT: PASS$" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

//--- tests/bar_cases.txt
# Columns: op bar word data tag expect, all numbers in hex
# op: T test name, W write, R read, Z read all words, S stall data cycles, L idle read
T reset_state
Z 0 0 0 00 00000000
Z 1 0 0 10 00000000
Z 2 0 0 20 00000000
T write_read
W 0 3 a5a50003 30 00000000
W 1 3 5a5a1003 31 00000000
W 2 3 c0de2003 32 00000000
R 0 3 0 33 a5a50003
R 1 3 0 34 5a5a1003
R 2 3 0 35 c0de2003
W 0 f 00000001 36 00000000
W 0 f 0000000f 37 00000000
R 0 f 0 38 0000000f
W 1 12 12121212 39 00000000
R 1 2 0 3a 12121212
R 2 2 0 3b 00000000
R 0 2 0 3c 00000000
T tag_match
R 0 3 0 40 a5a50003
R 1 3 0 41 5a5a1003
R 2 3 0 42 c0de2003
R 1 2 0 43 12121212
R 0 f 0 44 0000000f
T back_pressure
W 2 0 beef0000 50 00000000
R 2 0 0 51 beef0000
R 2 3 0 52 c0de2003
R 0 3 0 53 a5a50003
R 1 2 0 54 12121212
S 0 0 6 00 00000000
R 2 0 0 55 beef0000
R 1 3 0 56 5a5a1003
T unmapped_bar
W 3 5 deaddead 60 00000000
R 3 5 0 61 00000000
R 0 5 0 62 00000000
R 1 5 0 63 00000000
R 2 5 0 64 00000000
T unloaded_latency
L 0 3 0 70 a5a50003
L 2 0 0 71 beef0000

//--- tests/tb_clock.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset. rst_n is released on a falling edge
// after RESET_CYCLES rising edges
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter real PERIOD_NS    = 4.0,
    parameter int  RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- tests/tb_fpga_core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for fpga_core, driven from tests/bar_cases.txt (run from
// the project root). CC ready toggles at random except in latency reads.
// Tags must be unique among the reads in flight
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "pcie_consts.svh"

module tb_fpga_core;
    import pcie_pkg::*;

    localparam int TAGS  = 1 << `PCIE_TAG_WIDTH;
    localparam int WORDS = `PCIE_REGION_WORDS;

    logic       clk;
    logic       rst_n;
    logic       s_cq_valid;
    logic       s_cq_ready;
    logic       s_cq_write;
    bar_sel_t   s_cq_bar;
    pcie_addr_t s_cq_addr;
    pcie_data_t s_cq_data;
    pcie_tag_t  s_cq_tag;
    logic       m_cc_valid;
    logic       m_cc_ready;
    pcie_data_t m_cc_data;
    pcie_tag_t  m_cc_tag;
    logic       status_error_uncor;

    // Case table, one entry per line of the file
    string      op_q [$];
    string      name_q [$];
    int         bar_q [$];
    int         word_q [$];
    pcie_data_t data_q [$];
    int         tag_q [$];
    pcie_data_t exp_q [$];

    // Scoreboard by tag, issue side and completion side
    int         issued_cnt [TAGS];
    int         done_cnt [TAGS];
    pcie_data_t exp_data [TAGS];
    int         acc_cycle [TAGS];
    bit         lat_check [TAGS];

    int         issued_total;
    int         done_total;
    int         chk_main;
    int         err_main;
    int         chk_cc;
    int         err_cc;
    int         cycles;
    int         limit;
    int         case_count;
    int         test_count;
    int         chk_start;
    int         err_start;
    string      test_name;
    bit         in_test;
    bit         force_ready = 1'b0;

    tb_clock #(.PERIOD_NS(4.0), .RESET_CYCLES(10)) u_clock (.clk(clk), .rst_n(rst_n));

    fpga_core u_dut (
        .clk                (clk),
        .rst_n              (rst_n),
        .s_cq_valid         (s_cq_valid),
        .s_cq_ready         (s_cq_ready),
        .s_cq_write         (s_cq_write),
        .s_cq_bar           (s_cq_bar),
        .s_cq_addr          (s_cq_addr),
        .s_cq_data          (s_cq_data),
        .s_cq_tag           (s_cq_tag),
        .m_cc_valid         (m_cc_valid),
        .m_cc_ready         (m_cc_ready),
        .m_cc_data          (m_cc_data),
        .m_cc_tag           (m_cc_tag),
        .status_error_uncor (status_error_uncor)
    );

    initial begin : cc_ready_gen
        void'($urandom(32'hed8ac340));
        m_cc_ready = 1'b0;
        forever begin
            @(negedge clk);
            if (force_ready)
                m_cc_ready = 1'b1;
            else
                m_cc_ready = ($urandom() % 32'd3) != 32'd0;   // Low about a third of cycles
        end
    end

    // Run limit, counted on falling edges
    initial begin : watchdog
        cycles = 0;
        while (cycles <= limit) begin
            @(negedge clk);
            cycles = cycles + 1;
        end
        $display("Timeout after %0d cycles, %0d reads still open",
                 cycles, issued_total - done_total);
        $display("RESULT: FAIL");
        $finish;
    end

    // Completion collector
    always @(posedge clk) begin : collect
        bit known;
        if (rst_n && m_cc_valid && m_cc_ready) begin
            known = issued_cnt[m_cc_tag] > done_cnt[m_cc_tag];
            chk_cc++;
            assert (known) else begin
                $display("%0t: completion with tag %h was not requested or came twice",
                         $time, m_cc_tag);
                err_cc++;
            end
            if (known) begin
                chk_cc++;
                assert (m_cc_data == exp_data[m_cc_tag]) else begin
                    $display("ERR %0t m_cc_data expected %h got %h (tag %h)",
                             $time, exp_data[m_cc_tag], m_cc_data, m_cc_tag);
                    err_cc++;
                end
                if (lat_check[m_cc_tag]) begin
                    chk_cc++;
                    assert (cycles - acc_cycle[m_cc_tag] == 3) else begin
                        $display("%0t: read with tag %h completed after %0d cycles, not 3",
                                 $time, m_cc_tag, cycles - acc_cycle[m_cc_tag]);
                        err_cc++;
                    end
                end
                done_cnt[m_cc_tag]++;
                done_total++;
            end
        end
    end

    task automatic load_cases();
        int         fd;
        int         n;
        string      line;
        string      op;
        string      name;
        int         bar;
        int         word;
        int         tag;
        pcie_data_t data;
        pcie_data_t exp_val;
        fd = $fopen("tests/bar_cases.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the case file tests/bar_cases.txt");
            err_main++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() < 2 || line[0] == "#")
                    continue;
                bar = 0;
                word = 0;
                tag = 0;
                data = '0;
                exp_val = '0;
                name = "";
                n = $sscanf(line, "%s", op);
                if (op == "T")
                    n = $sscanf(line, "%s %s", op, name);
                else
                    n = $sscanf(line, "%s %h %h %h %h %h", op, bar, word, data, tag, exp_val);
                op_q.push_back(op);
                name_q.push_back(name);
                bar_q.push_back(bar);
                word_q.push_back(word);
                data_q.push_back(data);
                tag_q.push_back(tag);
                exp_q.push_back(exp_val);
                if (op == "Z")
                    case_count += WORDS;
                else if (op == "W" || op == "R" || op == "L")
                    case_count += 1;
            end
            $fclose(fd);
        end
    endtask

    // Called on a falling edge, returns on a falling edge
    task automatic send(input logic wr, input int bar, input int word, input pcie_data_t data,
                        input pcie_tag_t tag, input pcie_data_t exp_val, input bit lat);
        bit accepted;
        bit mapped;
        mapped = bar < `PCIE_REGION_COUNT;
        while (issued_cnt[tag] != done_cnt[tag])
            @(negedge clk);
        s_cq_valid = 1'b1;
        s_cq_write = wr;
        s_cq_bar   = bar_sel_t'(bar);
        s_cq_addr  = pcie_addr_t'(word * 4);
        s_cq_data  = data;
        s_cq_tag   = tag;
        accepted   = 1'b0;
        while (!accepted) begin
            accepted = s_cq_ready;   // Transfer on the coming rising edge
            @(posedge clk);
            if (!accepted)
                @(negedge clk);
        end
        if (!wr && mapped) begin
            exp_data[tag]  = exp_val;
            lat_check[tag] = lat;
            acc_cycle[tag] = cycles;
            issued_cnt[tag]++;
            issued_total++;
        end
        @(negedge clk);
        s_cq_valid = 1'b0;
        chk_main++;
        assert (status_error_uncor == !mapped) else begin
            $display("ERR %0t status_error_uncor expected %b got %b",
                     $time, !mapped, status_error_uncor);
            err_main++;
        end
        if (!mapped) begin
            @(negedge clk);   // Pulse must be one cycle long
            chk_main++;
            assert (status_error_uncor == 1'b0) else begin
                $display("ERR %0t status_error_uncor expected 0 got %b",
                         $time, status_error_uncor);
                err_main++;
            end
        end
    endtask

    task automatic drain();
        while (issued_total != done_total)
            @(negedge clk);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        in_test   = 1'b1;
        chk_start = chk_main + chk_cc;
        err_start = err_main + err_cc;
        test_count++;
    endtask

    task automatic finish_test();
        drain();
        repeat (8) @(negedge clk);   // Room for a stray completion to show up
        $display("test %s done: %0d checks, %0d errors", test_name,
                 chk_main + chk_cc - chk_start, err_main + err_cc - err_start);
        in_test = 1'b0;
    endtask

    task automatic latency_read(input int bar, input int word, input pcie_tag_t tag,
                                input pcie_data_t exp_val);
        drain();
        force_ready = 1'b1;
        repeat (2) @(negedge clk);   // Idle design, CC ready settled high
        send(1'b0, bar, word, '0, tag, exp_val, 1'b1);
        drain();
        force_ready = 1'b0;
    endtask

    initial begin : main
        s_cq_valid = 1'b0;
        s_cq_write = 1'b0;
        s_cq_bar   = '0;
        s_cq_addr  = '0;
        s_cq_data  = '0;
        s_cq_tag   = '0;
        load_cases();
        limit = 20 * case_count + 200;
        @(posedge rst_n);
        @(negedge clk);

        start_test("reset_outputs");
        chk_main += 3;
        assert (s_cq_ready == 1'b1) else begin
            $display("ERR %0t s_cq_ready expected 1 got %b", $time, s_cq_ready);
            err_main++;
        end
        assert (m_cc_valid == 1'b0) else begin
            $display("ERR %0t m_cc_valid expected 0 got %b", $time, m_cc_valid);
            err_main++;
        end
        assert (status_error_uncor == 1'b0) else begin
            $display("ERR %0t status_error_uncor expected 0 got %b",
                     $time, status_error_uncor);
            err_main++;
        end
        finish_test();

        for (int i = 0; i < op_q.size(); i++) begin
            if (op_q[i] == "T") begin
                if (in_test)
                    finish_test();
                start_test(name_q[i]);
            end else if (op_q[i] == "W") begin
                send(1'b1, bar_q[i], word_q[i], data_q[i], pcie_tag_t'(tag_q[i]), '0, 1'b0);
            end else if (op_q[i] == "R") begin
                send(1'b0, bar_q[i], word_q[i], '0, pcie_tag_t'(tag_q[i]), exp_q[i], 1'b0);
            end else if (op_q[i] == "Z") begin
                for (int w = 0; w < WORDS; w++)
                    send(1'b0, bar_q[i], w, '0, pcie_tag_t'(tag_q[i] + w), exp_q[i], 1'b0);
            end else if (op_q[i] == "S") begin
                repeat (int'(data_q[i])) @(negedge clk);
            end else if (op_q[i] == "L") begin
                latency_read(bar_q[i], word_q[i], pcie_tag_t'(tag_q[i]), exp_q[i]);
            end else begin
                $display("Unknown operation %s in the case file", op_q[i]);
                err_main++;
            end
        end
        if (in_test)
            finish_test();

        $display("%0d tests, %0d checks, %0d errors", test_count,
                 chk_main + chk_cc, err_main + err_cc);
        if (err_main + err_cc == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/bar_region.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One BAR register region. Only the word bits of the address decode,
// so accesses wrap at the region depth. One read may be outstanding
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "pcie_consts.svh"

module bar_region (
    input  logic     clk,
    input  logic     rst_n,
    pcie_req_if.dst  req,
    pcie_cpl_if.src  cpl
);
    import pcie_pkg::*;

    localparam int WORDS     = `PCIE_REGION_WORDS;
    localparam int WORD_BITS = $clog2(WORDS);

    pcie_data_t           regs [WORDS];
    region_state_t        state;
    pcie_data_t           slot_data;
    pcie_tag_t            slot_tag;
    logic [WORD_BITS-1:0] word;
    logic                 req_fire;
    logic                 rd_fire;

    assign word     = req.addr[2 +: WORD_BITS];   // Byte address to word index
    assign req.ready = (state == REG_IDLE);       // Full slot blocks the region
    assign req_fire = req.valid && req.ready;
    assign rd_fire  = req_fire && !req.write;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= REG_IDLE;
            for (int w = 0; w < WORDS; w++) begin
                regs[w] <= '0;
            end
        end else begin
            if (req_fire && req.write)
                regs[word] <= req.data;

            case (state)
                REG_IDLE: begin
                    if (rd_fire)
                        state <= REG_CPL_PENDING;
                end
                REG_CPL_PENDING: begin
                    if (cpl.ready)
                        state <= REG_IDLE;   // Drained by the arbiter
                end
                default: state <= REG_IDLE;
            endcase
        end
    end

    // Read data and tag captured on the accepting edge
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            slot_data <= regs[word];
            slot_tag  <= req.tag;
        end
    end

    assign cpl.valid = (state == REG_CPL_PENDING);
    assign cpl.data  = slot_data;
    assign cpl.tag   = slot_tag;

    a_cpl_stable: assert property (@(posedge clk) disable iff (!rst_n)
        cpl.valid && !cpl.ready |=> cpl.valid && $stable(cpl.data) && $stable(cpl.tag));

endmodule

`default_nettype wire

//--- verilog/cpl_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Round-robin merge of region completions onto one registered CC beat.
// No grant while the output beat is held by back-pressure
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "pcie_consts.svh"

module cpl_arbiter #(
    parameter int REGION_COUNT = `PCIE_REGION_COUNT
) (
    input  logic                 clk,
    input  logic                 rst_n,
    pcie_cpl_if.dst              region [REGION_COUNT],
    output logic                 cc_valid,
    input  logic                 cc_ready,
    output pcie_pkg::pcie_data_t cc_data,
    output pcie_pkg::pcie_tag_t  cc_tag
);
    import pcie_pkg::*;

    localparam int IDX_W = (REGION_COUNT > 1) ? $clog2(REGION_COUNT) : 1;

    logic [REGION_COUNT-1:0] cpl_valid;
    pcie_data_t              cpl_data [REGION_COUNT];
    pcie_tag_t               cpl_tag  [REGION_COUNT];
    logic [REGION_COUNT-1:0] grant;
    logic [IDX_W-1:0]        grant_idx;
    logic [IDX_W-1:0]        last;       // Last granted region
    logic                    out_free;

    assign out_free = !cc_valid || cc_ready;   // Empty or draining this edge

    for (genvar i = 0; i < REGION_COUNT; i++) begin : g_in
        assign cpl_valid[i]    = region[i].valid;
        assign cpl_data[i]     = region[i].data;
        assign cpl_tag[i]      = region[i].tag;
        assign region[i].ready = out_free && grant[i];
    end

    // Search starts one past the last winner
    always_comb begin
        int idx;
        grant     = '0;
        grant_idx = last;
        for (int k = 1; k <= REGION_COUNT; k++) begin
            idx = (int'(last) + k) % REGION_COUNT;
            if (cpl_valid[idx] && grant == '0) begin
                grant[idx] = 1'b1;
                grant_idx  = IDX_W'(idx);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cc_valid <= 1'b0;
            last     <= IDX_W'(REGION_COUNT - 1);   // Region 0 wins first
        end else if (out_free) begin
            cc_valid <= |grant;
            if (|grant)
                last <= grant_idx;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free && |grant) begin
            cc_data <= cpl_data[grant_idx];
            cc_tag  <= cpl_tag[grant_idx];
        end
    end

    a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(grant));

endmodule

`default_nettype wire

//--- verilog/fpga_core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Endpoint core for pre-decoded CQ requests. Writes give no completion.
// Unloaded read latency is three cycles, completions may reorder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "pcie_consts.svh"

module fpga_core #(
    parameter int REGION_COUNT = `PCIE_REGION_COUNT   // 1 to 4
) (
    input  logic                 clk,
    input  logic                 rst_n,

    // Completer request
    input  logic                 s_cq_valid,
    output logic                 s_cq_ready,
    input  logic                 s_cq_write,
    input  pcie_pkg::bar_sel_t   s_cq_bar,
    input  pcie_pkg::pcie_addr_t s_cq_addr,
    input  pcie_pkg::pcie_data_t s_cq_data,
    input  pcie_pkg::pcie_tag_t  s_cq_tag,

    // Completer completion
    output logic                 m_cc_valid,
    input  logic                 m_cc_ready,
    output pcie_pkg::pcie_data_t m_cc_data,
    output pcie_pkg::pcie_tag_t  m_cc_tag,

    output logic                 status_error_uncor   // Unmapped BAR request
);

    pcie_req_if req_bus [REGION_COUNT] ();
    pcie_cpl_if cpl_bus [REGION_COUNT] ();

    req_dispatch #(
        .REGION_COUNT(REGION_COUNT)
    ) u_dispatch (
        .clk         (clk),
        .rst_n       (rst_n),
        .cq_valid    (s_cq_valid),
        .cq_ready    (s_cq_ready),
        .cq_write    (s_cq_write),
        .cq_bar      (s_cq_bar),
        .cq_addr     (s_cq_addr),
        .cq_data     (s_cq_data),
        .cq_tag      (s_cq_tag),
        .region      (req_bus),
        .error_uncor (status_error_uncor)
    );

    for (genvar i = 0; i < REGION_COUNT; i++) begin : g_region
        bar_region u_region (
            .clk   (clk),
            .rst_n (rst_n),
            .req   (req_bus[i]),
            .cpl   (cpl_bus[i])
        );
    end

    cpl_arbiter #(
        .REGION_COUNT(REGION_COUNT)
    ) u_arbiter (
        .clk      (clk),
        .rst_n    (rst_n),
        .region   (cpl_bus),
        .cc_valid (m_cc_valid),
        .cc_ready (m_cc_ready),
        .cc_data  (m_cc_data),
        .cc_tag   (m_cc_tag)
    );

endmodule

`default_nettype wire

//--- verilog/pcie_consts.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sizing of the PCIe endpoint core. The region count may be 1 to 4 and
// must fit the BAR select width. Region depth must be a power of two
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef PCIE_CONSTS_SVH
`define PCIE_CONSTS_SVH

`define PCIE_DATA_WIDTH     32   // Register and payload width
`define PCIE_ADDR_WIDTH     12   // Byte address inside a BAR
`define PCIE_TAG_WIDTH      8
`define PCIE_BAR_SEL_WIDTH  2

// Implemented regions stand for BAR0, BAR2 and BAR4
`define PCIE_REGION_COUNT   3
`define PCIE_REGION_WORDS   16   // Word index wraps at this depth

`endif

//--- verilog/pcie_ifs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Internal request and completion links, one per BAR region.
// valid/ready handshake, payload held from valid until the transfer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

// Dispatcher to region
interface pcie_req_if;
    import pcie_pkg::*;

    logic       valid;
    logic       ready;
    logic       write;   // High for a write, low for a read
    pcie_addr_t addr;
    pcie_data_t data;
    pcie_tag_t  tag;

    modport src (
        output valid, write, addr, data, tag,
        input  ready
    );

    modport dst (
        input  valid, write, addr, data, tag,
        output ready
    );
endinterface

// Region to completion arbiter
interface pcie_cpl_if;
    import pcie_pkg::*;

    logic       valid;
    logic       ready;
    pcie_data_t data;
    pcie_tag_t  tag;

    modport src (output valid, data, tag, input ready);
    modport dst (input valid, data, tag, output ready);
endinterface

`default_nettype wire

//--- verilog/pcie_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types of the endpoint core, sized from pcie_consts.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "pcie_consts.svh"

package pcie_pkg;

    typedef logic [`PCIE_DATA_WIDTH-1:0]    pcie_data_t;
    typedef logic [`PCIE_ADDR_WIDTH-1:0]    pcie_addr_t;
    typedef logic [`PCIE_TAG_WIDTH-1:0]     pcie_tag_t;
    typedef logic [`PCIE_BAR_SEL_WIDTH-1:0] bar_sel_t;

    // Completion slot of one BAR region
    typedef enum logic {
        REG_IDLE,         // Slot empty, region takes requests
        REG_CPL_PENDING   // Read data waiting for the arbiter
    } region_state_t;

endpackage

`default_nettype wire

//--- verilog/req_dispatch.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CQ request dispatcher with a one-entry output stage. A request for a
// busy region stalls the CQ input. BAR selects past the last region are
// dropped and flagged for one cycle on error_uncor
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "pcie_consts.svh"

module req_dispatch #(
    parameter int REGION_COUNT = `PCIE_REGION_COUNT
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cq_valid,
    output logic                 cq_ready,
    input  logic                 cq_write,
    input  pcie_pkg::bar_sel_t   cq_bar,
    input  pcie_pkg::pcie_addr_t cq_addr,
    input  pcie_pkg::pcie_data_t cq_data,
    input  pcie_pkg::pcie_tag_t  cq_tag,
    pcie_req_if.src              region [REGION_COUNT],
    output logic                 error_uncor
);
    import pcie_pkg::*;

    localparam int SEL_SPAN = 1 << `PCIE_BAR_SEL_WIDTH;

    logic                    stage_valid;
    logic                    stage_write;
    bar_sel_t                stage_bar;
    pcie_addr_t              stage_addr;
    pcie_data_t              stage_data;
    pcie_tag_t               stage_tag;
    logic [SEL_SPAN-1:0]     region_ready;   // Zero for unmapped selects
    logic [REGION_COUNT-1:0] region_valid;
    logic                    stage_fire;
    logic                    cq_fire;
    logic                    bar_ok;

    assign stage_fire = stage_valid && region_ready[stage_bar];
    assign cq_ready   = !stage_valid || stage_fire;
    assign cq_fire    = cq_valid && cq_ready;
    assign bar_ok     = int'(cq_bar) < REGION_COUNT;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage_valid <= 1'b0;
            error_uncor <= 1'b0;
        end else begin
            error_uncor <= cq_fire && !bar_ok;   // Single cycle pulse
            if (cq_fire && bar_ok)
                stage_valid <= 1'b1;
            else if (stage_fire)
                stage_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (cq_fire && bar_ok) begin
            stage_write <= cq_write;
            stage_bar   <= cq_bar;
            stage_addr  <= cq_addr;
            stage_data  <= cq_data;
            stage_tag   <= cq_tag;
        end
    end

    for (genvar i = 0; i < SEL_SPAN; i++) begin : g_ready
        if (i < REGION_COUNT) begin : g_map
            assign region_ready[i] = region[i].ready;
        end else begin : g_unmap
            assign region_ready[i] = 1'b0;
        end
    end

    // Payload goes to every region, valid only to the selected one
    for (genvar i = 0; i < REGION_COUNT; i++) begin : g_out
        assign region_valid[i]  = stage_valid && (stage_bar == bar_sel_t'(i));
        assign region[i].valid  = region_valid[i];
        assign region[i].write  = stage_write;
        assign region[i].addr   = stage_addr;
        assign region[i].data   = stage_data;
        assign region[i].tag    = stage_tag;
    end

    // A staged request is valid on exactly one region
    a_one_region: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(region_valid) && (stage_valid == |region_valid));

endmodule

`default_nettype wire
